//--- fetch_unit.f
rtl/fetch_pkg.sv
rtl/pc_select.sv
rtl/fetch_ctrl.sv
rtl/inst_buffer.sv
rtl/decode_issue.sv
rtl/fetch_unit.sv
tests/fetch_unit_assertions.sv
tests/fetch_unit_tb.sv

//--- run_sim.sh
#!/bin/bash
# Build and run the fetch_unit testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f fetch_unit.f --top-module fetch_unit_tb \
    --Mdir obj_dir -o fetch_unit_sim

./obj_dir/fetch_unit_sim | tee sim.log || true

if grep -q "Test failures found" sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q "All tests passed!" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi

//--- tests/fetch_unit_tb.sv
/*
 * Testbench for fetch_unit with cache and decode models and a PC scoreboard.
 * Cache words equal their byte address XOR 32'h5a5a0000.
 */

`timescale 1ns/1ps

module fetch_unit_tb;

    import fetch_pkg::*;

    localparam int          max_cycles = 4000;
    localparam logic [31:0] pattern    = 32'h5a5a0000;

    logic          clock = 1'b0;
    logic          reset;
    redirect_t     resolved_branch;
    redirect_t     predicted_branch;
    icache_rsp_t   icache_rsp;
    logic          credit_return;
    logic          icache_req;
    logic [31:0]   icache_addr;
    fetch_packet_t issue_packet;

    int          cycle = 0;
    int          errors = 0;
    int          tests = 0;
    int          issued = 0;
    logic [31:0] exp_pc = 32'h0;
    logic        pred_pending = 1'b0;
    logic [31:0] pred_target;
    logic        withhold = 1'b0;
    int          due_q[$];

    fetch_unit fetch_unit_inst (
        .clock            (clock),
        .reset            (reset),
        .resolved_branch  (resolved_branch),
        .predicted_branch (predicted_branch),
        .icache_rsp       (icache_rsp),
        .credit_return    (credit_return),
        .icache_req       (icache_req),
        .icache_addr      (icache_addr),
        .issue_packet     (issue_packet)
    );

    bind fetch_unit fetch_unit_assertions assertions_inst (
        .clock           (clock),
        .reset           (reset),
        .icache_req      (icache_req),
        .icache_rsp      (icache_rsp),
        .resolved_branch (resolved_branch),
        .issue_packet    (issue_packet),
        .credit_return   (credit_return)
    );

    always #2 clock = ~clock;

    always @(posedge clock) begin
        cycle++;
        if (cycle >= max_cycles) begin
            $display("timeout: the tests did not finish within %0d cycles", max_cycles);
            $display("Test failures found");
            $finish;
        end
    end

    // cache model, one line per request after 1 to 4 cycles
    initial begin
        logic [31:0] addr;
        int          delay;
        forever begin
            @(posedge clock);
            if (icache_req && !reset) begin
                addr  = icache_addr;
                delay = $urandom % 4 + 1;
                repeat (delay - 1) @(posedge clock);
                @(negedge clock);
                icache_rsp.data  = {(addr + 32'd4) ^ pattern, addr ^ pattern};
                icache_rsp.valid = 1'b1;
                @(negedge clock);
                icache_rsp.valid = 1'b0;
            end
        end
    end

    // decode model and scoreboard
    always @(posedge clock) begin
        if (!reset && issue_packet.valid) begin
            issued++;
            due_q.push_back(cycle + $urandom % 7);
            if (pred_pending && issue_packet.pc == pred_target) begin
                pred_pending = 1'b0;
            end else begin
                pc_order: assert (issue_packet.pc == exp_pc) else begin
                    $display("FAIL %0t: pc %h, expected %h", $time, issue_packet.pc, exp_pc);
                    errors++;
                end
            end
            npc_ok: assert (issue_packet.npc == issue_packet.pc + 32'd4) else begin
                $display("FAIL %0t: npc %h for pc %h", $time, issue_packet.npc,
                         issue_packet.pc);
                errors++;
            end
            inst_ok: assert (issue_packet.inst == (issue_packet.pc ^ pattern)) else begin
                $display("FAIL %0t: inst %h for pc %h", $time, issue_packet.inst,
                         issue_packet.pc);
                errors++;
            end
            exp_pc = issue_packet.pc + 32'd4;
        end
    end

    always @(negedge clock) begin
        credit_return = 1'b0;
        if (!withhold && due_q.size() > 0 && due_q[0] <= cycle) begin
            credit_return = 1'b1;
            void'(due_q.pop_front());
        end
    end

    task automatic wait_issued(input int n);
        int target;
        target = issued + n;
        while (issued < target) @(posedge clock);
    endtask

    task automatic wait_fetch_start();
        do @(posedge clock); while (!icache_req || reset);
    endtask

    task automatic check(input logic ok, input string msg);
        if (!ok) begin
            $display("FAIL %0t: %s", $time, msg);
            errors++;
        end
    endtask

    task automatic report(input string name);
        tests++;
        $display("test %s finished, errors so far %0d", name, errors);
    endtask

    initial begin
        int start;
        int reqs;
        void'($urandom(32'hddbb15ab));
        reset            = 1'b1;
        resolved_branch  = '0;
        predicted_branch = '0;
        icache_rsp       = '0;
        credit_return    = 1'b0;
        repeat (5) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        wait_fetch_start();
        check(icache_addr == 32'h0, "first fetch address is not the reset PC");
        check(issued == 0, "a packet was issued before the first fetch");
        report("reset");

        wait_issued(40);
        report("sequential");

        @(negedge clock);
        pred_target      = 32'h0000_0400;
        pred_pending     = 1'b1;
        predicted_branch = '{req: 1'b1, pc: pred_target};
        wait_fetch_start();
        @(negedge clock);
        predicted_branch = '0;
        wait_issued(12);
        check(!pred_pending, "predicted target was never issued");
        report("predicted");

        // pulse while a response is in flight, with a competing prediction
        wait_fetch_start();
        @(negedge clock);
        resolved_branch  = '{req: 1'b1, pc: 32'h0000_0804};
        predicted_branch = '{req: 1'b1, pc: 32'h0000_0c00};
        @(posedge clock);
        #1;
        exp_pc       = 32'h0000_0804;
        pred_pending = 1'b0;
        @(negedge clock);
        resolved_branch = '0;
        // prediction stays up until the redirected fetch has started
        wait_fetch_start();
        @(negedge clock);
        predicted_branch = '0;
        wait_issued(12);
        report("resolved");

        withhold = 1'b1;
        start    = issued;
        repeat (60) @(posedge clock);
        check(issued - start <= 4, "more packets issued than decode credits");
        report("credits");

        repeat (60) @(posedge clock);
        reqs = 0;
        repeat (20) begin
            @(posedge clock);
            if (icache_req) reqs++;
        end
        check(reqs == 0, "fetching did not stop with the buffer full");
        withhold = 1'b0;
        wait_issued(30);
        report("buffer full");

        errors += fetch_unit_inst.assertions_inst.fail_count;
        $display("tests run %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- tests/fetch_unit_assertions.sv
/*
 * Protocol checks bound into fetch_unit.
 * Credit count is rebuilt from issue valid and credit_return seen at the ports.
 */

`timescale 1ns/1ps

module fetch_unit_assertions #(
    parameter int DECODE_CREDITS = 4
) (
    input logic                     clock,
    input logic                     reset,
    input logic                     icache_req,
    input fetch_pkg::icache_rsp_t   icache_rsp,
    input fetch_pkg::redirect_t     resolved_branch,
    input fetch_pkg::fetch_packet_t issue_packet,
    input logic                     credit_return
);

    import fetch_pkg::*;

    logic outstanding;
    int   credits;
    int   fail_count = 0;

    always_ff @(posedge clock) begin
        if (reset) begin
            outstanding <= 1'b0;
        end else if (icache_req) begin
            outstanding <= 1'b1;
        end else if (icache_rsp.valid) begin
            outstanding <= 1'b0;
        end
    end

    // credits as decode sees them
    always_ff @(posedge clock) begin
        if (reset) begin
            credits <= DECODE_CREDITS;
        end else begin
            credits <= credits - int'(issue_packet.valid) + int'(credit_return);
        end
    end

    one_outstanding: assert property (@(posedge clock) disable iff (reset)
        outstanding |-> !icache_req)
        else begin
            $error("cache request issued while another was outstanding");
            fail_count++;
        end

    issue_needs_credit: assert property (@(posedge clock) disable iff (reset)
        issue_packet.valid |-> credits > 0)
        else begin
            $error("packet issued with no decode credit left");
            fail_count++;
        end

    flush_clears_issue: assert property (@(posedge clock) disable iff (reset)
        resolved_branch.req |=> !issue_packet.valid)
        else begin
            $error("packet issued in the cycle after a resolved branch");
            fail_count++;
        end

    reset_quiet: assert property (@(posedge clock)
        reset |=> !issue_packet.valid)
        else begin
            $error("packet issued right after reset");
            fail_count++;
        end

    reset_no_req: assert property (@(posedge clock)
        reset |-> !icache_req)
        else begin
            $error("cache request issued while reset was held");
            fail_count++;
        end

endmodule

//--- rtl/fetch_unit.sv
/*
 * Instruction fetch top. One word per cycle at most, no compressed instructions.
 * The cache sits outside and answers each line request exactly once.
 * A resolved branch flushes the buffer and the issue register.
 */

`timescale 1ns/1ps

module fetch_unit #(
    parameter int                          BUF_DEPTH      = 8,
    parameter int                          DECODE_CREDITS = 4,
    parameter logic [fetch_pkg::xlen-1:0]  RESET_PC       = '0
) (
    input  logic                       clock,
    input  logic                       reset,
    input  fetch_pkg::redirect_t       resolved_branch,
    input  fetch_pkg::redirect_t       predicted_branch,
    input  fetch_pkg::icache_rsp_t     icache_rsp,
    input  logic                       credit_return,
    output logic                       icache_req,
    output logic [fetch_pkg::xlen-1:0] icache_addr,
    output fetch_pkg::fetch_packet_t   issue_packet
);

    import fetch_pkg::*;

    logic                       flush;
    logic                       buf_push;
    fetch_packet_t              push_packet;
    fetch_packet_t              head_packet;
    logic                       buf_empty;
    logic [$clog2(BUF_DEPTH):0] buf_count;
    logic                       buf_pop;

    assign flush = resolved_branch.req;

    fetch_ctrl #(
        .BUF_DEPTH (BUF_DEPTH),
        .RESET_PC  (RESET_PC)
    ) fetch_ctrl_inst (
        .clock            (clock),
        .reset            (reset),
        .resolved_branch  (resolved_branch),
        .predicted_branch (predicted_branch),
        .icache_rsp       (icache_rsp),
        .buf_count        (buf_count),
        .icache_req       (icache_req),
        .icache_addr      (icache_addr),
        .buf_push         (buf_push),
        .push_packet      (push_packet)
    );

    inst_buffer #(
        .BUF_DEPTH (BUF_DEPTH)
    ) inst_buffer_inst (
        .clock       (clock),
        .reset       (reset),
        .flush       (flush),
        .push        (buf_push),
        .push_packet (push_packet),
        .pop         (buf_pop),
        .head_packet (head_packet),
        .empty       (buf_empty),
        .count       (buf_count)
    );

    decode_issue #(
        .DECODE_CREDITS (DECODE_CREDITS)
    ) decode_issue_inst (
        .clock         (clock),
        .reset         (reset),
        .flush         (flush),
        .head_packet   (head_packet),
        .empty         (buf_empty),
        .credit_return (credit_return),
        .pop           (buf_pop),
        .issue_packet  (issue_packet)
    );

endmodule

//--- rtl/decode_issue.sv
/*
 * Registered packet output to decode with a credit counter.
 * Credits start full and come back one per cycle of credit_return.
 * Flush clears the output valid on the same edge and leaves credits alone.
 */

`timescale 1ns/1ps

module decode_issue #(
    parameter int DECODE_CREDITS = 4
) (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      flush,
    input  fetch_pkg::fetch_packet_t  head_packet,
    input  logic                      empty,
    input  logic                      credit_return,
    output logic                      pop,
    output fetch_pkg::fetch_packet_t  issue_packet
);

    import fetch_pkg::*;

    localparam int               crd_w    = $clog2(DECODE_CREDITS + 1);
    localparam logic [crd_w-1:0] max_crd  = crd_w'(DECODE_CREDITS);

    logic [crd_w-1:0] credits;
    logic             issue_valid;
    fetch_packet_t    issue_q;

    assign pop = !empty && (credits != '0) && !flush;

    // return and consume may cancel in one cycle
    always_ff @(posedge clock) begin
        if (reset) begin
            credits <= max_crd;
        end else begin
            case ({pop, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= (credits == max_crd) ? credits : credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= pop;
        end
    end

    always_ff @(posedge clock) begin
        if (pop) begin
            issue_q <= head_packet;
        end
    end

    always_comb begin
        issue_packet       = issue_q;
        issue_packet.valid = issue_valid;
    end

endmodule

//--- rtl/inst_buffer.sv
/*
 * Circular FIFO of fetch packets. BUF_DEPTH must be a power of two.
 * Push and pop may share a cycle. Flush wins over a push in the same cycle.
 * The head entry is read combinationally.
 */

`timescale 1ns/1ps

module inst_buffer #(
    parameter int BUF_DEPTH = 8
) (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          flush,
    input  logic                          push,
    input  fetch_pkg::fetch_packet_t      push_packet,
    input  logic                          pop,
    output fetch_pkg::fetch_packet_t      head_packet,
    output logic                          empty,
    output logic [$clog2(BUF_DEPTH):0]    count
);

    import fetch_pkg::*;

    localparam int idx_w = $clog2(BUF_DEPTH);
    localparam int cnt_w = idx_w + 1;

    fetch_packet_t    mem [BUF_DEPTH];
    logic [idx_w-1:0] head;
    logic [idx_w-1:0] tail;
    logic             pop_ok;

    assign empty  = (count == '0);
    assign pop_ok = pop && !empty;

    always_ff @(posedge clock) begin
        if (reset || flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push) begin
                tail <= tail + 1'b1;
            end
            if (pop_ok) begin
                head <= head + 1'b1;
            end
            case ({push, pop_ok})
                2'b10:   count <= count + cnt_w'(1);
                2'b01:   count <= count - cnt_w'(1);
                default: count <= count;
            endcase
        end
    end

    // storage
    always_ff @(posedge clock) begin
        if (push) begin
            mem[tail] <= push_packet;
        end
    end

    assign head_packet = mem[head];

endmodule

//--- rtl/fetch_ctrl.sv
/*
 * Fetch FSM with one outstanding cache request at a time.
 * A fetch starts only while the buffer has room, so a push never overflows.
 * A response is dropped when a resolved redirect came in while it was in flight.
 */

`timescale 1ns/1ps

module fetch_ctrl #(
    parameter int                          BUF_DEPTH = 8,
    parameter logic [fetch_pkg::xlen-1:0]  RESET_PC  = '0
) (
    input  logic                           clock,
    input  logic                           reset,
    input  fetch_pkg::redirect_t           resolved_branch,
    input  fetch_pkg::redirect_t           predicted_branch,
    input  fetch_pkg::icache_rsp_t         icache_rsp,
    input  logic [$clog2(BUF_DEPTH):0]     buf_count,
    output logic                           icache_req,
    output logic [fetch_pkg::xlen-1:0]     icache_addr,
    output logic                           buf_push,
    output fetch_pkg::fetch_packet_t       push_packet
);

    import fetch_pkg::*;

    localparam int                cnt_w      = $clog2(BUF_DEPTH) + 1;
    localparam logic [cnt_w-1:0]  full_count = cnt_w'(BUF_DEPTH);

    typedef enum logic {
        st_idle,
        st_wait
    } state_t;

    state_t          state;
    logic            first_q;
    logic [xlen-1:0] pc_q;
    logic [xlen-1:0] next_pc;
    logic [xlen-1:0] start_pc;
    logic            redirect_pending;
    logic            fetch_start;
    logic            rsp_accept;
    logic [xlen-1:0] word;

    pc_select pc_select_inst (
        .clock            (clock),
        .reset            (reset),
        .resolved_branch  (resolved_branch),
        .predicted_branch (predicted_branch),
        .fetch_pc         (pc_q),
        .fetch_start      (fetch_start),
        .next_pc          (next_pc),
        .redirect_pending (redirect_pending)
    );

    // no request goes out while reset is held
    assign fetch_start = !reset && (state == st_idle) && (buf_count < full_count);

    // first fetch goes to RESET_PC unless execute already redirected
    assign start_pc = (first_q && !redirect_pending) ? RESET_PC : next_pc;

    // line aligned request, issued in the start cycle
    assign icache_req  = fetch_start;
    assign icache_addr = {start_pc[xlen-1:3], 3'b000};

    always_ff @(posedge clock) begin
        if (reset) begin
            state   <= st_idle;
            first_q <= 1'b1;
            pc_q    <= RESET_PC;
        end else begin
            case (state)
                st_idle: begin
                    if (fetch_start) begin
                        state   <= st_wait;
                        first_q <= 1'b0;
                        pc_q    <= start_pc;
                    end
                end
                st_wait: begin
                    if (icache_rsp.valid) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    assign rsp_accept = (state == st_wait) && icache_rsp.valid;
    assign buf_push   = rsp_accept && !redirect_pending;

    // PC bit 2 picks the half of the line
    assign word = pc_q[2] ? icache_rsp.data[line_bits-1:xlen] : icache_rsp.data[xlen-1:0];

    always_comb begin
        push_packet.inst  = buf_push ? word : nop_inst;
        push_packet.pc    = pc_q;
        push_packet.npc   = pc_q + 32'd4;
        push_packet.valid = buf_push;
    end

endmodule

//--- rtl/pc_select.sv
/*
 * Next fetch PC by priority: resolved branch, predicted target, then PC+4.
 * A resolved redirect is held until a fetch starts with it. A newer pulse
 * replaces an older one that has not been used yet.
 */

`timescale 1ns/1ps

module pc_select (
    input  logic                          clock,
    input  logic                          reset,
    input  fetch_pkg::redirect_t          resolved_branch,
    input  fetch_pkg::redirect_t          predicted_branch,
    input  logic [fetch_pkg::xlen-1:0]    fetch_pc,
    input  logic                          fetch_start,
    output logic [fetch_pkg::xlen-1:0]    next_pc,
    output logic                          redirect_pending
);

    import fetch_pkg::*;

    logic            held_valid;
    logic [xlen-1:0] held_pc;

    // held redirect, consumed by the next fetch start
    always_ff @(posedge clock) begin
        if (reset) begin
            held_valid <= 1'b0;
        end else if (fetch_start) begin
            held_valid <= 1'b0;
        end else if (resolved_branch.req) begin
            held_valid <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (resolved_branch.req) begin
            held_pc <= resolved_branch.pc;
        end
    end

    // a pulse in the start cycle itself is taken directly
    always_comb begin
        if (resolved_branch.req) begin
            next_pc = resolved_branch.pc;
        end else if (held_valid) begin
            next_pc = held_pc;
        end else if (predicted_branch.req) begin
            next_pc = predicted_branch.pc;
        end else begin
            next_pc = fetch_pc + 32'd4;
        end
    end

    // the fetch in flight is on the wrong path
    assign redirect_pending = held_valid | resolved_branch.req;

endmodule

//--- rtl/fetch_pkg.sv
/*
 * Shared widths and packet types of the fetch subsystem.
 * xlen is fixed by the ISA. Cache lines are 64 bits, so each line holds two words.
 */

package fetch_pkg;

    // address and data width
    localparam int xlen = 32;

    // one cache line carries two instruction words
    localparam int line_bits = 64;

    // canonical no-op, addi x0, x0, 0
    localparam logic [xlen-1:0] nop_inst = 32'h0000_0013;

    // one fetched instruction on its way to decode
    typedef struct packed {
        logic [xlen-1:0] inst;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] npc;
        logic            valid;
    } fetch_packet_t;

    // response from the instruction cache
    typedef struct packed {
        logic [line_bits-1:0] data;
        logic                 valid;
    } icache_rsp_t;

    // resolved branch from execute or predicted branch target
    typedef struct packed {
        logic            req;
        logic [xlen-1:0] pc;
    } redirect_t;

endpackage
